// File: filelist.f
+incdir+include
verilog/mem_bus_pkg.sv
verilog/icache_pkg.sv
verilog/icache_store.sv
verilog/icache_lookup.sv
verilog/icache_refill_ctrl.sv
verilog/icache_top.sv
verif/icache_mem_model.sv
verif/icache_tb.sv

// File: include/icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// cache geometry for the direct-mapped instruction cache
// one way only, so index plus offset cover the low address bits

// byte offset bits inside a line
`define ICACHE_OFFSET_BITS 4

// 32-bit words in one line
`define ICACHE_WORDS (1 << (`ICACHE_OFFSET_BITS - 2))

// line index bits, 16 lines by default
`define ICACHE_INDEX_BITS 4

// whatever is left of the 32-bit address
`define ICACHE_TAG_BITS (32 - `ICACHE_INDEX_BITS - `ICACHE_OFFSET_BITS)

// address layout
//   [31 : index+offset]     tag
//   [index+offset-1 : off]  index
//   [off-1 : 2]             word in line
//   [1 : 0]                 byte, ignored for fetches

`endif

// File: run_sim.sh
#!/bin/sh
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module icache_tb -f filelist.f -o icache_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/icache_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi
exit 1

// File: verif/icache_mem_model.sv
`timescale 1ns/10ps

// memory responder for the cache refill bus
// address accept and data return have their own random delays
// words come back in the order their addresses were accepted
module icache_mem_model (
	input  logic                clk,
	input  logic                reset,
	input  logic                mem_req,
	input  mem_bus_pkg::addr_t  mem_addr,
	output logic                mem_addr_ok,
	output mem_bus_pkg::word_t  mem_rdata,
	output logic                mem_data_ok,
	output int                  accept_count
);

	logic [31:0]         rng_state;     // xorshift state
	mem_bus_pkg::addr_t  pend_addr [$]; // accepted, data still owed
	int                  pend_ready [$]; // first cycle each word may return
	int                  cycle;         // edges seen so far
	int                  addr_wait;     // cycles until mem_addr_ok rises

	// 32-bit xorshift step
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// next random value in 0 .. span-1
	function automatic int rand_below(input int span);
		rng_state = xorshift(rng_state);
		return int'(rng_state % span);
	endfunction

	// memory contents as a fixed function of the byte address
	function automatic mem_bus_pkg::word_t mem_word(input mem_bus_pkg::addr_t a);
		return (a ^ 32'h5a5a_0000) + (a >> 2);
	endfunction

	initial begin
		logic                seen_reset;
		logic                took_addr;
		logic                took_data;
		mem_bus_pkg::addr_t  addr_now;
		rng_state    = 32'h3b2a_57e5;
		mem_addr_ok  = 1'b0;
		mem_data_ok  = 1'b0;
		mem_rdata    = '0;
		accept_count = 0;
		cycle        = 0;
		addr_wait    = 0;
		forever begin
			// mid-cycle, all bus signals settled
			@(negedge clk);
			seen_reset = reset;
			took_addr  = mem_req && mem_addr_ok; // accepted on the coming edge
			took_data  = mem_data_ok;
			addr_now   = mem_addr;
			@(posedge clk);
			#5;
			cycle++;
			if (seen_reset) begin
				pend_addr.delete();
				pend_ready.delete();
				addr_wait    = rand_below(4);
				accept_count = 0;
			end else begin
				if (took_data && pend_addr.size() > 0) begin
					void'(pend_addr.pop_front()); // head word delivered
					void'(pend_ready.pop_front());
				end
				if (took_addr) begin
					pend_addr.push_back(addr_now);
					pend_ready.push_back(cycle + 1 + rand_below(4)); // 1..4 cycles
					accept_count++;
					addr_wait = rand_below(4); // 0..3 before the next accept
				end else if (addr_wait > 0) begin
					addr_wait--;
				end
			end
			mem_addr_ok = !seen_reset && (addr_wait == 0);
			// only the oldest word can return
			if (!seen_reset && pend_addr.size() > 0 && cycle >= pend_ready[0]) begin
				mem_data_ok = 1'b1;
				mem_rdata   = mem_word(pend_addr[0]);
			end else begin
				mem_data_ok = 1'b0;
				mem_rdata   = '0;
			end
		end
	end

endmodule

// File: verif/icache_tb.sv
`timescale 1ns/10ps
`include "icache_defines.svh"

// testbench for the direct-mapped instruction cache
// table driven fetches, refill traffic checked word by word
module icache_tb;

	typedef struct packed {
		mem_bus_pkg::addr_t addr;   // fetch address
		logic               refill; // line must come from memory
	} access_t;

	localparam int ROWS = 20;
	localparam int TIMEOUT_CYCLES = 200;

	// index is addr[7:4], tag is addr[31:8]
	access_t access_tab [ROWS] = '{
		'{32'h0000_1004, 1'b1}, // cold miss, index 0
		'{32'h0000_1000, 1'b0}, // rest of the line hits
		'{32'h0000_1008, 1'b0},
		'{32'h0000_100c, 1'b0},
		'{32'h0000_2004, 1'b1}, // index 0, new tag, evicts
		'{32'h0000_2000, 1'b0},
		'{32'h0000_1004, 1'b1}, // old line gone
		'{32'h0000_1010, 1'b1}, // cold miss, index 1
		'{32'h0000_101c, 1'b0},
		'{32'h0000_1014, 1'b0},
		'{32'h0000_1018, 1'b0},
		'{32'h0000_1000, 1'b0}, // index 0 holds tag 0x10 again
		'{32'h8000_00f0, 1'b1}, // top index, high tag
		'{32'h8000_00fc, 1'b0},
		'{32'h8000_00f4, 1'b0},
		'{32'h8000_00f8, 1'b0},
		'{32'h0000_20f8, 1'b1}, // evicts index 15
		'{32'h0000_1010, 1'b0}, // index 1 untouched
		'{32'h4000_0f20, 1'b1}, // index 2
		'{32'h4000_0f2c, 1'b0}
	};

	logic                clk;
	logic                reset;
	logic                cpu_req;
	mem_bus_pkg::addr_t  cpu_addr;
	mem_bus_pkg::word_t  cpu_rdata;
	logic                cpu_data_ok;
	logic                mem_req;
	mem_bus_pkg::addr_t  mem_addr;
	logic                mem_addr_ok;
	mem_bus_pkg::word_t  mem_rdata;
	logic                mem_data_ok;
	int                  accept_count; // from the memory model
	int                  errors;
	mem_bus_pkg::addr_t  accepted_q [$]; // refill addresses of the current access

	icache_top i_icache_top (
		.clk         (clk),
		.reset       (reset),
		.cpu_req     (cpu_req),
		.cpu_addr    (cpu_addr),
		.cpu_rdata   (cpu_rdata),
		.cpu_data_ok (cpu_data_ok),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.mem_addr_ok (mem_addr_ok),
		.mem_rdata   (mem_rdata),
		.mem_data_ok (mem_data_ok)
	);

	icache_mem_model i_mem_model (
		.clk          (clk),
		.reset        (reset),
		.mem_req      (mem_req),
		.mem_addr     (mem_addr),
		.mem_addr_ok  (mem_addr_ok),
		.mem_rdata    (mem_rdata),
		.mem_data_ok  (mem_data_ok),
		.accept_count (accept_count)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	// word the memory holds at a byte address
	function automatic mem_bus_pkg::word_t expected_word(input mem_bus_pkg::addr_t a);
		return (a ^ 32'h5a5a_0000) + (a >> 2);
	endfunction

	task automatic check_word(input string name, input mem_bus_pkg::word_t actual,
			input mem_bus_pkg::word_t expected);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s = %h, expected %h", $time, name, actual, expected);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int actual, input int expected);
		if (actual != expected) begin
			$display("Mismatch at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input mem_bus_pkg::addr_t actual,
			input mem_bus_pkg::addr_t expected);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s = %h, expected %h", $time, name, actual, expected);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s = %b, expected %b", $time, name, actual, expected);
			errors++;
		end
	endtask

	// an accept happens on the edge after a mid-cycle req and ok
	always @(negedge clk) begin
		if (!reset && mem_req && mem_addr_ok) begin
			accepted_q.push_back(mem_addr);
		end
	end

	initial begin
		int                  waited;
		int                  count_before;
		int                  count_after;
		int                  want_count;
		logic                got_data;
		logic                timed_out;
		mem_bus_pkg::addr_t  base;
		reset     = 1'b1;
		cpu_req   = 1'b0;
		cpu_addr  = '0;
		errors    = 0;
		timed_out = 1'b0;
		repeat (10) @(posedge clk);
		#5;
		reset = 1'b0;
		@(negedge clk);
		check_flag("mem_req", mem_req, 1'b0); // quiet bus after reset
		check_flag("cpu_data_ok", cpu_data_ok, 1'b0);

		for (int row = 0; row < ROWS && !timed_out; row++) begin
			@(negedge clk);
			count_before = accept_count;
			@(posedge clk);
			#5;
			accepted_q.delete();
			cpu_addr = access_tab[row].addr;
			cpu_req  = 1'b1; // held until cpu_data_ok
			got_data = 1'b0;
			waited   = 0;
			count_after = count_before;
			while (!got_data && waited < TIMEOUT_CYCLES) begin
				@(negedge clk);
				if (cpu_data_ok) begin
					got_data    = 1'b1;
					count_after = accept_count;
					check_word("cpu_rdata", cpu_rdata, expected_word(access_tab[row].addr));
				end else begin
					waited++;
				end
			end
			@(posedge clk);
			#5;
			cpu_req = 1'b0;
			if (!got_data) begin
				$display("Timeout: no cpu_data_ok within %0d cycles for fetch address %h",
					TIMEOUT_CYCLES, access_tab[row].addr);
				errors++;
				timed_out = 1'b1;
			end else begin
				want_count = access_tab[row].refill ? `ICACHE_WORDS : 0;
				check_count("accepted mem addresses", count_after - count_before, want_count);
				check_count("observed mem accepts", accepted_q.size(), want_count);
				// refill walks the line from its base, a line is four bytes per word
				base = access_tab[row].addr & ~mem_bus_pkg::addr_t'(4 * `ICACHE_WORDS - 1);
				for (int w = 0; w < accepted_q.size(); w++) begin
					check_addr("mem_addr", accepted_q[w], base + mem_bus_pkg::addr_t'(4 * w));
				end
			end
		end

		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: verilog/icache_lookup.sv
`timescale 1ns/10ps
`include "icache_defines.svh"

// address split, tag compare and word select
// everything here is combinational so a hit answers in the request cycle
module icache_lookup (
	input  logic                    cpu_req,
	input  mem_bus_pkg::addr_t      cpu_addr,
	input  icache_pkg::tag_entry_t  tag_entry,
	input  icache_pkg::line_t       line,
	output icache_pkg::index_t      index,
	output icache_pkg::word_sel_t   word_sel,
	output mem_bus_pkg::addr_t      line_base,
	output icache_pkg::tag_t        new_tag,
	output logic                    hit,
	output mem_bus_pkg::word_t      cpu_rdata,
	output logic                    cpu_data_ok
);

	logic tag_match; // stored tag equals the fetch tag

	// tag from the top bits
	assign new_tag  = cpu_addr[31 -: `ICACHE_TAG_BITS];
	// index sits just above the line offset
	assign index    = cpu_addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
	// word inside the line, byte bits dropped
	assign word_sel = cpu_addr[2 +: `ICACHE_OFFSET_BITS - 2];

	// first byte of the line, refill starts here
	assign line_base = {cpu_addr[31:`ICACHE_OFFSET_BITS], {`ICACHE_OFFSET_BITS{1'b0}}};

	assign tag_match = (tag_entry.tag == new_tag);

	// valid guards lines never filled since reset
	assign hit = tag_entry.valid && tag_match;

	// word select straight from the line store output
	assign cpu_rdata = line[word_sel];

	// one pulse per request, the cpu drops cpu_req after it
	assign cpu_data_ok = cpu_req && hit;

endmodule

// File: verilog/icache_pkg.sv
`include "icache_defines.svh"

// types describing how the cache is organized
package icache_pkg;

	// upper address bits kept per line
	typedef logic [`ICACHE_TAG_BITS-1:0] tag_t;

	// selects one of the lines
	typedef logic [`ICACHE_INDEX_BITS-1:0] index_t;

	// word position inside a line, also used by the refill counters
	typedef logic [`ICACHE_OFFSET_BITS-3:0] word_sel_t;

	// one tag store entry
	typedef struct packed {
		logic valid; // set once the line has been filled
		tag_t tag;
	} tag_entry_t;

	// whole line, word 0 in the low bits
	typedef logic [`ICACHE_WORDS-1:0][31:0] line_t;

endpackage

// File: verilog/icache_refill_ctrl.sv
`timescale 1ns/10ps
`include "icache_defines.svh"

// line refill engine
// address side and data side run independently, so several word
// addresses can be in flight before the first data beat comes back
module icache_refill_ctrl (
	input  logic                clk,
	input  logic                reset,
	input  logic                cpu_req,
	input  logic                hit,
	input  mem_bus_pkg::addr_t  line_base,
	input  logic                mem_addr_ok,
	input  logic                mem_data_ok,
	input  mem_bus_pkg::word_t  mem_rdata,
	output logic                mem_req,
	output mem_bus_pkg::addr_t  mem_addr,
	output logic                fill_en,
	output icache_pkg::line_t   fill_line
);

	typedef enum logic {
		IDLE   = 1'b0,
		REFILL = 1'b1
	} state_t;

	// highest word position in a line
	localparam icache_pkg::word_sel_t LAST_WORD = icache_pkg::word_sel_t'(`ICACHE_WORDS - 1);

	state_t                 state;
	icache_pkg::word_sel_t  addr_cnt; // next word address to hand out
	icache_pkg::word_sel_t  data_cnt; // slot for the next returning word
	logic                   start;    // miss seen while idle
	logic                   addr_take; // address accepted this cycle
	logic                   data_take; // data beat this cycle
	logic                   last_data; // final beat of the line
	mem_bus_pkg::addr_t     word_off;

	assign start     = (state == IDLE) && cpu_req && !hit;
	assign addr_take = (state == REFILL) && mem_req && mem_addr_ok;
	assign data_take = (state == REFILL) && mem_data_ok;
	assign last_data = data_take && (data_cnt == LAST_WORD);

	// byte offset of the current word
	assign word_off = mem_bus_pkg::addr_t'({addr_cnt, 2'b00});
	assign mem_addr = line_base + word_off;

	// two-state machine
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (start) begin
						state <= REFILL; // miss, go fetch the line
					end
				end
				REFILL: begin
					// leave once the fill pulse has gone out
					// stores take the line on this same edge
					if (fill_en) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// address side
	always_ff @(posedge clk) begin
		if (reset) begin
			addr_cnt <= '0;
			mem_req  <= 1'b0;
		end else if (start) begin
			addr_cnt <= '0;
			mem_req  <= 1'b1; // first address goes out next cycle
		end else if (addr_take) begin
			addr_cnt <= addr_cnt + 1'b1; // wraps after the last word, harmless
			if (addr_cnt == LAST_WORD) begin
				mem_req <= 1'b0; // whole line requested
			end
		end
	end

	// data side counter
	always_ff @(posedge clk) begin
		if (reset) begin
			data_cnt <= '0;
		end else if (start) begin
			data_cnt <= '0;
		end else if (data_take) begin
			data_cnt <= data_cnt + 1'b1;
		end
	end

	// line assembly buffer, no reset needed
	always_ff @(posedge clk) begin
		if (data_take) begin
			fill_line[data_cnt] <= mem_rdata; // in-order return
		end
	end

	// fill pulse one cycle after the last beat lands
	always_ff @(posedge clk) begin
		if (reset) begin
			fill_en <= 1'b0;
		end else begin
			fill_en <= last_data && !fill_en;
		end
	end

endmodule

// File: verilog/icache_store.sv
`timescale 1ns/10ps
`include "icache_defines.svh"

// small register array, one entry per cache line
// write on the clock edge, read straight through
module icache_store #(
	parameter type entry_t = logic [31:0],
	parameter int DEPTH = 1 << `ICACHE_INDEX_BITS
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                we,
	input  icache_pkg::index_t  waddr,
	input  entry_t              wdata,
	input  icache_pkg::index_t  raddr,
	output entry_t              rdata
);

	entry_t mem [DEPTH]; // one slot per index

	// clearing everything drops all valid flags in the tag store
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[waddr] <= wdata; // fill from the refill controller
		end
	end

	// combinational read for same-cycle hits
	assign rdata = mem[raddr];

endmodule

// File: verilog/icache_top.sv
`timescale 1ns/10ps
`include "icache_defines.svh"

// direct-mapped instruction cache
// hits return in the request cycle, misses refill the line then hit
module icache_top (
	input  logic                clk,
	input  logic                reset,
	input  logic                cpu_req,
	input  mem_bus_pkg::addr_t  cpu_addr,
	output mem_bus_pkg::word_t  cpu_rdata,
	output logic                cpu_data_ok,
	output logic                mem_req,
	output mem_bus_pkg::addr_t  mem_addr,
	input  logic                mem_addr_ok,
	input  mem_bus_pkg::word_t  mem_rdata,
	input  logic                mem_data_ok
);

	icache_pkg::index_t      index;
	mem_bus_pkg::addr_t      line_base;
	icache_pkg::tag_t        new_tag;
	logic                    hit;
	icache_pkg::tag_entry_t  tag_entry; // tag store read
	icache_pkg::tag_entry_t  tag_wdata; // tag store write
	icache_pkg::line_t       line;      // line store read
	icache_pkg::line_t       fill_line; // assembled refill line
	logic                    fill_en;

	// a filled line is valid right away
	assign tag_wdata = '{valid: 1'b1, tag: new_tag};

	icache_lookup i_lookup (
		.cpu_req     (cpu_req),
		.cpu_addr    (cpu_addr),
		.tag_entry   (tag_entry),
		.line        (line),
		.index       (index),
		.word_sel    (),
		.line_base   (line_base),
		.new_tag     (new_tag),
		.hit         (hit),
		.cpu_rdata   (cpu_rdata),
		.cpu_data_ok (cpu_data_ok)
	);

	// valid and tag per line
	icache_store #(
		.entry_t (icache_pkg::tag_entry_t)
	) i_tag_store (
		.clk   (clk),
		.reset (reset),
		.we    (fill_en),
		.waddr (index), // cpu_addr is held through the refill
		.wdata (tag_wdata),
		.raddr (index),
		.rdata (tag_entry)
	);

	// instruction words, written together with the tag
	icache_store #(
		.entry_t (icache_pkg::line_t)
	) i_line_store (
		.clk   (clk),
		.reset (reset),
		.we    (fill_en),
		.waddr (index),
		.wdata (fill_line),
		.raddr (index),
		.rdata (line)
	);

	icache_refill_ctrl i_refill_ctrl (
		.clk         (clk),
		.reset       (reset),
		.cpu_req     (cpu_req),
		.hit         (hit),
		.line_base   (line_base),
		.mem_addr_ok (mem_addr_ok),
		.mem_data_ok (mem_data_ok),
		.mem_rdata   (mem_rdata),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.fill_en     (fill_en),
		.fill_line   (fill_line)
	);

endmodule

// File: verilog/mem_bus_pkg.sv
`include "icache_defines.svh"

// word and address types shared by the cpu and memory sides
package mem_bus_pkg;

	// byte address, fetches are word aligned
	typedef logic [31:0] addr_t;

	// instruction word on the cpu side, refill beat on the memory side
	typedef logic [31:0] word_t;

endpackage
